//--- src/sdram_cmd_pkg.sv
package sdram_cmd_pkg;

  // --------------------
  // Bus commands
  typedef enum logic [2:0]
  {
    ARSR = 3'b001,  // Auto refresh
    PRCH = 3'b010,  // Row close
    ACTV = 3'b011,  // Row open
    WRTE = 3'b100,
    READ = 3'b101,
    BTRM = 3'b110,  // Burst terminate
    NOOP = 3'b111
  } sdram_cmd_t;

  typedef logic [13:0] row_t;
  typedef logic [2:0]  bank_t;
  typedef logic [8:0]  col_t;
  typedef logic [16:0] page_t;    // Row above bank
  typedef logic [3:0]  settle_t;

  localparam row_t PRECHARGE_ALL_ADDR = 14'h0400;  // A10 selects all banks

  // --------------------
  // Command spacing
  localparam settle_t SETTLE_LOAD_ARSR  = 4'd3;
  localparam settle_t SETTLE_LOAD_ACTV  = 4'd12;
  localparam settle_t SETTLE_LOAD_NOOP  = 4'd14;
  localparam settle_t SETTLE_LOAD_OTHER = 4'd11;

  localparam settle_t SETTLE_DONE_NORM  = 4'd14;
  localparam settle_t SETTLE_DONE_ALT   = 4'd13;
  localparam settle_t SETTLE_DONE_WRITE = 4'd15;  // Write recovery before close

  localparam logic [2:0] ACTV_WAIT = 3'd4;

endpackage

//--- src/host_port_pkg.sv
package host_port_pkg;

  // --------------------
  // Host address layout
  //   [25:12] row
  //   [11:9]  bank
  //   [8:0]   column
  typedef logic [25:0] host_addr_t;

  // One bit per 16-bit chunk
  typedef logic [3:0] we_mask_t;

  localparam int ROW_LSB  = 12;
  localparam int BANK_LSB = 9;

endpackage

//--- src/sched_if.sv
`timescale 1ns/10ps

interface sched_if;
  import sdram_cmd_pkg::*;

  // From the tracker
  logic       page_open;
  page_t      open_page;
  logic       last_was_write;
  logic       refresh_due;
  logic       may_change;       // Settle counter expired
  logic       actv_expired;

  // From the issuer
  logic       issued;           // Command register loads next edge
  sdram_cmd_t issued_cmd;
  page_t      issued_page;

  modport tracker
  (
    output page_open, open_page, last_was_write, refresh_due, may_change, actv_expired,
    input  issued, issued_cmd, issued_page
  );

  modport issuer
  (
    input  page_open, open_page, last_was_write, refresh_due, may_change, actv_expired,
    output issued, issued_cmd, issued_page
  );

endinterface

//--- src/request_capture.sv
`timescale 1ns/10ps

module request_capture
(
  input  logic                      INPUT_CLK,
  input  logic                      RST,
  input  host_port_pkg::host_addr_t rand_addr,
  input  logic                      rand_we,
  input  logic                      rand_req,
  input  host_port_pkg::we_mask_t   rand_mask,
  input  host_port_pkg::host_addr_t bulk_addr,
  input  logic                      bulk_we,
  input  logic                      bulk_req,
  input  host_port_pkg::we_mask_t   bulk_mask,
  input  logic                      page_open,
  input  sdram_cmd_pkg::page_t      open_page,
  input  logic                      refresh_due,
  output logic                      q_rand_req,
  output logic                      q_rand_we,
  output host_port_pkg::host_addr_t q_rand_addr,
  output host_port_pkg::we_mask_t   q_rand_mask,
  output logic                      q_bulk_req,
  output logic                      q_bulk_we,
  output host_port_pkg::host_addr_t q_bulk_addr,
  output host_port_pkg::we_mask_t   q_bulk_mask,
  output logic                      rand_hit,
  output logic                      bulk_hit,
  output logic                      any_hit
);
  import sdram_cmd_pkg::*;
  import host_port_pkg::*;

  page_t rand_page;
  page_t bulk_page;
  logic  hit_ok;
  logic  rand_hit_w;
  logic  bulk_hit_w;

  assign rand_page = q_rand_addr[$bits(host_addr_t)-1:BANK_LSB];
  assign bulk_page = q_bulk_addr[$bits(host_addr_t)-1:BANK_LSB];

  assign hit_ok     = page_open && !refresh_due;       // Pending refresh closes the row
  assign bulk_hit_w = hit_ok && q_bulk_req && (bulk_page == open_page);
  assign rand_hit_w = hit_ok && q_rand_req && !q_bulk_req && (rand_page == open_page);

  always_ff @(posedge INPUT_CLK)
  begin
    q_rand_we   <= rand_we;
    q_rand_addr <= rand_addr;
    q_rand_mask <= rand_mask;
    q_bulk_we   <= bulk_we;
    q_bulk_addr <= bulk_addr;
    q_bulk_mask <= bulk_mask;
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      q_rand_req <= 1'b0;
      q_bulk_req <= 1'b0;
      rand_hit   <= 1'b0;
      bulk_hit   <= 1'b0;
      any_hit    <= 1'b0;
    end
    else
    begin
      q_rand_req <= rand_req;
      q_bulk_req <= bulk_req;
      rand_hit   <= rand_hit_w;   // One cycle behind the captured request
      bulk_hit   <= bulk_hit_w;
      any_hit    <= rand_hit_w || bulk_hit_w;
    end
  end

  a_one_hit: assert property (@(posedge INPUT_CLK) disable iff (RST)
    !(rand_hit && bulk_hit));

endmodule

//--- src/bank_state_tracker.sv
`timescale 1ns/10ps

module bank_state_tracker
(
  input  logic                 INPUT_CLK,
  input  logic                 RST,
  input  logic                 refresh_strobe,
  sched_if.tracker             st,
  output logic                 page_open,
  output sdram_cmd_pkg::page_t open_page,
  output logic                 refresh_due
);
  import sdram_cmd_pkg::*;

  logic       pend_valid;    // Command is on the bus this cycle
  sdram_cmd_t pend_cmd;
  page_t      pend_page;
  logic       open_q;
  logic       write_q;
  page_t      page_q;
  logic       strobe_q;
  logic       strobe_ack;
  logic       refresh_time;
  logic       due_q;
  settle_t    settle_cnt;
  logic       settle_done;
  logic [2:0] actv_cnt;

  // After a write the row needs the longer recovery
  assign settle_done = write_q ? (settle_cnt == SETTLE_DONE_WRITE) :
                       ((settle_cnt == SETTLE_DONE_NORM) || (settle_cnt == SETTLE_DONE_ALT));

  always_ff @(posedge INPUT_CLK)
  begin
    pend_cmd  <= st.issued_cmd;
    pend_page <= st.issued_page;
    if (RST)
      pend_valid <= 1'b0;
    else
      pend_valid <= st.issued;
  end

  // --------------------
  // Open page and refresh debt
  always_ff @(posedge INPUT_CLK)
  begin
    if (pend_valid && (pend_cmd == ACTV))
      page_q <= pend_page;
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      open_q       <= 1'b0;
      write_q      <= 1'b0;
      strobe_q     <= refresh_strobe;
      strobe_ack   <= refresh_strobe;   // No debt out of reset
      refresh_time <= 1'b0;
      due_q        <= 1'b0;
    end
    else
    begin
      strobe_q     <= refresh_strobe;
      refresh_time <= strobe_q ^ strobe_ack;
      due_q        <= refresh_time;
      if (pend_valid)
      begin
        if (pend_cmd == ACTV)
          open_q <= 1'b1;
        if (pend_cmd == PRCH)
          open_q <= 1'b0;
        write_q <= (pend_cmd == WRTE);
        if (pend_cmd == ARSR)
        begin
          strobe_ack   <= strobe_q;
          refresh_time <= 1'b0;
          due_q        <= 1'b0;
        end
      end
    end
  end

  // --------------------
  // Settle and activate timers
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      settle_cnt <= SETTLE_LOAD_NOOP;
      actv_cnt   <= ACTV_WAIT;
    end
    else
    begin
      if (pend_valid)
      begin
        case (pend_cmd)
          ARSR:    settle_cnt <= SETTLE_LOAD_ARSR;
          ACTV:    settle_cnt <= SETTLE_LOAD_ACTV;
          NOOP:    settle_cnt <= SETTLE_LOAD_NOOP;
          default: settle_cnt <= SETTLE_LOAD_OTHER;
        endcase
      end
      else if (!settle_done)
        settle_cnt <= settle_cnt + 4'd1;

      if (pend_valid && (pend_cmd == ACTV))
        actv_cnt <= 3'd0;
      else if (actv_cnt != ACTV_WAIT)
        actv_cnt <= actv_cnt + 3'd1;
    end
  end

  assign st.page_open      = open_q;
  assign st.open_page      = page_q;
  assign st.last_was_write = write_q;
  assign st.refresh_due    = due_q;
  assign st.may_change     = settle_done && !pend_valid;
  assign st.actv_expired   = (actv_cnt == ACTV_WAIT);

  assign page_open   = open_q;
  assign open_page   = page_q;
  assign refresh_due = due_q;

  // Issuer must wait for the row to close first
  a_no_actv_on_open: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (st.issued && (st.issued_cmd == ACTV)) |-> !open_q);

endmodule

//--- src/command_issuer.sv
`timescale 1ns/10ps

module command_issuer
(
  input  logic                       INPUT_CLK,
  input  logic                       RST,
  input  logic                       q_rand_req,
  input  logic                       q_rand_we,
  input  host_port_pkg::host_addr_t  q_rand_addr,
  input  host_port_pkg::we_mask_t    q_rand_mask,
  input  logic                       q_bulk_req,
  input  logic                       q_bulk_we,
  input  host_port_pkg::host_addr_t  q_bulk_addr,
  input  host_port_pkg::we_mask_t    q_bulk_mask,
  input  logic                       rand_hit,
  input  logic                       bulk_hit,
  input  logic                       any_hit,
  sched_if.issuer                    st,
  output sdram_cmd_pkg::sdram_cmd_t  command_reg,
  output sdram_cmd_pkg::row_t        address_reg,
  output sdram_cmd_pkg::bank_t       bank_reg,
  output logic                       grant_rand,
  output logic                       grant_bulk,
  output host_port_pkg::we_mask_t    we_mask
);
  import sdram_cmd_pkg::*;
  import host_port_pkg::*;

  logic [1:0] hold_cnt;      // Covers stale requests and hits after a command
  logic       rand_seen;
  logic       bulk_seen;
  logic       last_rw;
  logic       win_we;
  logic       rand_miss;
  logic       bulk_miss;
  logic       any_miss;
  logic       hit_go;
  logic       issue;
  host_addr_t win_addr;
  host_addr_t req_addr;
  col_t       win_col;
  sdram_cmd_t next_cmd;
  row_t       next_addr;
  bank_t      next_bank;

  assign win_addr = bulk_hit ? q_bulk_addr : q_rand_addr;
  assign win_we   = bulk_hit ? q_bulk_we : q_rand_we;
  assign win_col  = win_addr[BANK_LSB-1:0];
  assign req_addr = q_bulk_req ? q_bulk_addr : q_rand_addr;   // Bulk first

  // A miss only counts once its hit flag has caught up
  assign bulk_miss = q_bulk_req && bulk_seen && !bulk_hit;
  assign rand_miss = !q_bulk_req && q_rand_req && rand_seen && !rand_hit;
  assign any_miss  = bulk_miss || rand_miss;

  // Same direction as the last access skips the settle wait
  assign hit_go = any_hit && (hold_cnt == 2'd0) &&
                  (st.may_change || (last_rw && (st.last_was_write == win_we)));

  always_comb
  begin
    next_cmd  = NOOP;
    next_addr = PRECHARGE_ALL_ADDR;
    next_bank = st.open_page[$bits(bank_t)-1:0];
    if (hit_go)
    begin
      next_cmd  = win_we ? WRTE : READ;
      next_addr = {4'h0, win_col, 1'b0};
      next_bank = win_addr[ROW_LSB-1:BANK_LSB];
    end
    else if ((hold_cnt == 2'd0) && st.may_change)
    begin
      if (st.page_open)
      begin
        if (st.actv_expired && (st.refresh_due || any_miss))
          next_cmd = PRCH;
      end
      else if (st.refresh_due)
        next_cmd = ARSR;
      else if (any_miss)
      begin
        next_cmd  = ACTV;
        next_addr = req_addr[$bits(host_addr_t)-1:ROW_LSB];
        next_bank = req_addr[ROW_LSB-1:BANK_LSB];
      end
    end
  end

  assign issue = (next_cmd != NOOP);

  assign st.issued      = issue;
  assign st.issued_cmd  = next_cmd;
  assign st.issued_page = req_addr[$bits(host_addr_t)-1:BANK_LSB];

  always_ff @(posedge INPUT_CLK)
  begin
    if (issue)
    begin
      address_reg <= next_addr;
      bank_reg    <= next_bank;
    end
    if (hit_go)
      we_mask <= bulk_hit ? q_bulk_mask : q_rand_mask;
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      command_reg <= NOOP;
      grant_rand  <= 1'b0;
      grant_bulk  <= 1'b0;
      hold_cnt    <= 2'd0;
      last_rw     <= 1'b0;
      rand_seen   <= 1'b0;
      bulk_seen   <= 1'b0;
    end
    else
    begin
      command_reg <= next_cmd;
      grant_bulk  <= hit_go && bulk_hit;
      grant_rand  <= hit_go && !bulk_hit;
      rand_seen   <= q_rand_req;
      bulk_seen   <= q_bulk_req;
      if (issue)
      begin
        hold_cnt <= 2'd3;
        last_rw  <= hit_go;
      end
      else if (hold_cnt != 2'd0)
        hold_cnt <= hold_cnt - 2'd1;
    end
  end

  a_grant_with_rw: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (grant_rand || grant_bulk) |-> ((command_reg == READ) || (command_reg == WRTE)));

endmodule

//--- src/sdram_scheduler_top.sv
`timescale 1ns/10ps

module sdram_scheduler_top
(
  input  logic                      INPUT_CLK,
  input  logic                      RST,
  input  logic                      refresh_strobe,
  input  host_port_pkg::host_addr_t rand_addr,
  input  logic                      rand_we,
  input  logic                      rand_req,
  input  host_port_pkg::we_mask_t   rand_mask,
  input  host_port_pkg::host_addr_t bulk_addr,
  input  logic                      bulk_we,
  input  logic                      bulk_req,
  input  host_port_pkg::we_mask_t   bulk_mask,
  output sdram_cmd_pkg::sdram_cmd_t command_reg,
  output sdram_cmd_pkg::row_t       address_reg,
  output sdram_cmd_pkg::bank_t      bank_reg,
  output logic                      grant_rand,
  output logic                      grant_bulk,
  output host_port_pkg::we_mask_t   we_mask
);
  import sdram_cmd_pkg::*;
  import host_port_pkg::*;

  logic       q_rand_req, q_rand_we, q_bulk_req, q_bulk_we;
  host_addr_t q_rand_addr, q_bulk_addr;
  we_mask_t   q_rand_mask, q_bulk_mask;
  logic       rand_hit, bulk_hit, any_hit;
  logic       page_open, refresh_due;
  page_t      open_page;

  sched_if i_st ();

  request_capture i_capture
  (
    .INPUT_CLK (INPUT_CLK),   .RST        (RST),
    .rand_addr (rand_addr),   .rand_we    (rand_we),    .rand_req   (rand_req),
    .rand_mask (rand_mask),   .bulk_addr  (bulk_addr),  .bulk_we    (bulk_we),
    .bulk_req  (bulk_req),    .bulk_mask  (bulk_mask),  .page_open  (page_open),
    .open_page (open_page),   .refresh_due (refresh_due),
    .q_rand_req (q_rand_req), .q_rand_we  (q_rand_we),  .q_rand_addr (q_rand_addr),
    .q_rand_mask (q_rand_mask), .q_bulk_req (q_bulk_req), .q_bulk_we (q_bulk_we),
    .q_bulk_addr (q_bulk_addr), .q_bulk_mask (q_bulk_mask),
    .rand_hit  (rand_hit),    .bulk_hit   (bulk_hit),   .any_hit    (any_hit)
  );

  bank_state_tracker i_tracker
  (
    .INPUT_CLK (INPUT_CLK),   .RST        (RST),        .refresh_strobe (refresh_strobe),
    .st        (i_st),        .page_open  (page_open),  .open_page  (open_page),
    .refresh_due (refresh_due)
  );

  command_issuer i_issuer
  (
    .INPUT_CLK (INPUT_CLK),   .RST        (RST),
    .q_rand_req (q_rand_req), .q_rand_we  (q_rand_we),  .q_rand_addr (q_rand_addr),
    .q_rand_mask (q_rand_mask), .q_bulk_req (q_bulk_req), .q_bulk_we (q_bulk_we),
    .q_bulk_addr (q_bulk_addr), .q_bulk_mask (q_bulk_mask),
    .rand_hit  (rand_hit),    .bulk_hit   (bulk_hit),   .any_hit    (any_hit),
    .st        (i_st),        .command_reg (command_reg), .address_reg (address_reg),
    .bank_reg  (bank_reg),    .grant_rand (grant_rand), .grant_bulk (grant_bulk),
    .we_mask   (we_mask)
  );

endmodule

//--- verif/sched_checks.sv
`timescale 1ns/10ps

module sched_checks
(
  input  logic                      INPUT_CLK,
  input  logic                      RST,
  input  logic                      refresh_strobe,
  input  host_port_pkg::host_addr_t rand_addr,
  input  logic                      rand_we,
  input  logic                      rand_req,
  input  host_port_pkg::we_mask_t   rand_mask,
  input  host_port_pkg::host_addr_t bulk_addr,
  input  logic                      bulk_we,
  input  logic                      bulk_req,
  input  host_port_pkg::we_mask_t   bulk_mask,
  input  sdram_cmd_pkg::sdram_cmd_t command_reg,
  input  sdram_cmd_pkg::row_t       address_reg,
  input  sdram_cmd_pkg::bank_t      bank_reg,
  input  logic                      grant_rand,
  input  logic                      grant_bulk,
  input  host_port_pkg::we_mask_t   we_mask,
  output int                        errors
);
  import sdram_cmd_pkg::*;
  import host_port_pkg::*;

  int         error_count;
  logic       req_seen;
  logic       row_open;       // Row state seen on the command bus
  row_t       actv_row;
  bank_t      actv_bank;
  logic       strobe_prev;
  int         refresh_debt;
  host_addr_t grant_addr;

  assign errors     = error_count;
  assign grant_addr = grant_bulk ? bulk_addr : rand_addr;

  initial error_count = 0;

  task automatic log_failure(input string msg);
    error_count++;
    $display("[FAIL] %0d ns: %s", $time, msg);
  endtask

  function automatic sdram_cmd_t rw_cmd(input logic we);
    return we ? WRTE : READ;
  endfunction

  // Column goes out one place up
  function automatic row_t col_field(input host_addr_t addr);
    return row_t'(addr[8:0]) << 1;
  endfunction

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      req_seen     <= 1'b0;
      row_open     <= 1'b0;
      strobe_prev  <= refresh_strobe;
      refresh_debt <= 0;
    end
    else
    begin
      strobe_prev <= refresh_strobe;
      if (rand_req || bulk_req)
        req_seen <= 1'b1;
      if (command_reg == ACTV)
      begin
        row_open  <= 1'b1;
        actv_row  <= address_reg;
        actv_bank <= bank_reg;
      end
      if (command_reg == PRCH)
        row_open <= 1'b0;
      if ((refresh_strobe != strobe_prev) && (command_reg != ARSR))
        refresh_debt <= refresh_debt + 1;
      else if ((refresh_strobe == strobe_prev) && (command_reg == ARSR) && (refresh_debt > 0))
        refresh_debt <= refresh_debt - 1;
    end
  end

  // --------------------
  a_quiet_until_request: assert property (@(posedge INPUT_CLK) disable iff (RST)
    !req_seen |-> ((command_reg == NOOP) && !grant_rand && !grant_bulk))
    else log_failure("command or grant before the first request");

  a_noop_after_cmd: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (command_reg != NOOP) |=> (command_reg == NOOP))
    else log_failure("two commands back to back");

  a_bulk_grant: assert property (@(posedge INPUT_CLK) disable iff (RST)
    grant_bulk |-> (bulk_req && (command_reg == rw_cmd(bulk_we)) &&
      (address_reg == col_field(bulk_addr)) && (bank_reg == bulk_addr[11:9]) &&
      (we_mask == bulk_mask)))
    else log_failure("bulk grant does not match its request");

  a_rand_grant: assert property (@(posedge INPUT_CLK) disable iff (RST)
    grant_rand |-> (rand_req && (command_reg == rw_cmd(rand_we)) &&
      (address_reg == col_field(rand_addr)) && (bank_reg == rand_addr[11:9]) &&
      (we_mask == rand_mask)))
    else log_failure("random grant does not match its request");

  a_bulk_first: assert property (@(posedge INPUT_CLK) disable iff (RST)
    grant_rand |-> !$past(bulk_req, 3))   // Capture and hit stages
    else log_failure("random port granted over a waiting bulk request");

  a_grant_page: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (grant_rand || grant_bulk) |-> (row_open && (actv_row == grant_addr[25:12]) &&
      (actv_bank == grant_addr[11:9])))
    else log_failure("access to a row and bank that the last ACTV did not open");

  // --------------------
  a_prch_all: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (command_reg == PRCH) |-> (address_reg == 14'h0400))
    else log_failure("PRCH without the all-banks address");

  a_actv_closed: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (command_reg == ACTV) |-> !row_open)
    else log_failure("ACTV while a row is open");

  a_arsr_closed: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (command_reg == ARSR) |-> !row_open)
    else log_failure("ARSR while a row is open");

  a_arsr_owed: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (command_reg == ARSR) |-> (refresh_debt > 0))
    else log_failure("ARSR without a refresh strobe toggle");

endmodule

//--- verif/tb_sdram_scheduler.sv
`timescale 1ns/10ps

module tb_sdram_scheduler;
  import sdram_cmd_pkg::*;
  import host_port_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int IDLE_CYCLES  = 8;
  localparam int WAIT_LIMIT   = 600;   // Cycles
  localparam int BULK_REQS    = 16;
  localparam int RAND_REQS    = 40;
  localparam int REFRESHES    = 6;

  logic       INPUT_CLK;
  logic       RST;
  logic       refresh_strobe;
  host_addr_t rand_addr;
  logic       rand_we;
  logic       rand_req;
  we_mask_t   rand_mask;
  host_addr_t bulk_addr;
  logic       bulk_we;
  logic       bulk_req;
  we_mask_t   bulk_mask;
  sdram_cmd_t command_reg;
  row_t       address_reg;
  bank_t      bank_reg;
  logic       grant_rand;
  logic       grant_bulk;
  we_mask_t   we_mask;
  page_t      hot_page;   // Shared by both ports to force hits
  int         check_errors;
  int         timeouts;
  int         grants;

  sdram_scheduler_top i_dut (.*);

  sched_checks i_checks (.errors (check_errors), .*);

  initial
  begin
    INPUT_CLK = 1'b0;
    forever #20 INPUT_CLK = ~INPUT_CLK;
  end

  function automatic host_addr_t pick_addr();
    int unsigned r;
    r = $urandom();
    if (r[31:30] == 2'd0)
      hot_page = r[25:9];
    if (r[29])
      return {hot_page, r[8:0]};
    return r[25:0];
  endfunction

  task automatic await_grant(input logic from_bulk, output logic got);
    int cycles;
    got    = 1'b0;
    cycles = 0;
    while (!got && (cycles < WAIT_LIMIT))
    begin
      @(negedge INPUT_CLK);   // Mid-cycle sample
      got = from_bulk ? grant_bulk : grant_rand;
      cycles++;
    end
    if (got)
      grants++;
  endtask

  task automatic expect_refresh(output logic got);
    int cycles;
    got    = 1'b0;
    cycles = 0;
    while (!got && (cycles < WAIT_LIMIT))
    begin
      @(negedge INPUT_CLK);
      got = (command_reg == ARSR);
      cycles++;
    end
  endtask

  // --------------------
  task automatic bulk_traffic();
    int unsigned r;
    host_addr_t  addr;
    logic        got;
    for (int i = 0; i < BULK_REQS; i++)
    begin
      r    = $urandom();
      addr = pick_addr();
      bulk_addr <= addr;
      bulk_we   <= r[0];
      bulk_mask <= r[7:4];
      bulk_req  <= 1'b1;
      await_grant(1'b1, got);
      if (!got)
      begin
        $display("Timeout: a bulk port request was never granted");
        timeouts++;
      end
      @(posedge INPUT_CLK);
      bulk_req <= 1'b0;
      repeat (12 + (r % 24)) @(posedge INPUT_CLK);   // Leave room for the random port
    end
  endtask

  task automatic random_traffic();
    int unsigned r;
    host_addr_t  addr;
    logic        got;
    for (int i = 0; i < RAND_REQS; i++)
    begin
      r    = $urandom();
      addr = pick_addr();
      rand_addr <= addr;
      rand_we   <= r[0];
      rand_mask <= r[7:4];
      rand_req  <= 1'b1;
      await_grant(1'b0, got);
      if (!got)
      begin
        $display("Timeout: a random port request was never granted");
        timeouts++;
      end
      @(posedge INPUT_CLK);
      rand_req <= 1'b0;
      repeat (2 + (r % 8)) @(posedge INPUT_CLK);
    end
  endtask

  task automatic refresh_toggles();
    int unsigned r;
    logic        got;
    for (int i = 0; i < REFRESHES; i++)
    begin
      r = $urandom();
      repeat (40 + (r % 64)) @(posedge INPUT_CLK);
      refresh_strobe <= ~refresh_strobe;
      expect_refresh(got);
      if (!got)
      begin
        $display("Timeout: no ARSR followed a refresh strobe toggle");
        timeouts++;
      end
    end
  endtask

  // --------------------
  initial
  begin
    void'($urandom(32'h8ad4_7fc9));
    RST            = 1'b1;
    refresh_strobe = 1'b0;
    rand_addr      = '0;
    rand_we        = 1'b0;
    rand_req       = 1'b0;
    rand_mask      = '0;
    bulk_addr      = '0;
    bulk_we        = 1'b0;
    bulk_req       = 1'b0;
    bulk_mask      = '0;
    hot_page       = '0;
    timeouts       = 0;
    grants         = 0;
    repeat (RESET_CYCLES) @(posedge INPUT_CLK);
    RST <= 1'b0;
    repeat (IDLE_CYCLES) @(posedge INPUT_CLK);   // Quiet bus before any request
    fork
      bulk_traffic();
      random_traffic();
      refresh_toggles();
    join
    repeat (10) @(posedge INPUT_CLK);
    $display("Assertion errors: %0d, timeouts: %0d, grants: %0d",
             check_errors, timeouts, grants);
    if ((check_errors == 0) && (timeouts == 0))
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- compile.f
src/sdram_cmd_pkg.sv
src/host_port_pkg.sv
src/sched_if.sv
src/request_capture.sv
src/bank_state_tracker.sv
src/command_issuer.sv
src/sdram_scheduler_top.sv
verif/sched_checks.sv
verif/tb_sdram_scheduler.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_sdram_scheduler
FILELIST := compile.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Everything OK

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
